// ==== verilog/fpu_pkg.sv ====
`default_nettype none

package fpu_pkg;

   // IEEE single-precision field layout
   localparam int exp_w    = 8;
   localparam int man_w    = 23;
   localparam int exp_bias = 127;

   // Wide working registers (X/Y)
   localparam int wide_frac_w = 50;
   localparam int norm_bit    = 47;    // Leading one of a normalized X fraction

   // Micro-program counter
   localparam int upc_w = 4;

   // Decoded operations
   typedef enum logic [3:0] {
      op_none,
      op_fadd,
      op_fsub,
      op_fmul,
      op_feq,
      op_flt,
      op_fle,
      op_fmin,
      op_fmax,
      op_fsgnj,
      op_fsgnjn,
      op_fsgnjx,
      op_fclass,
      op_fmv                           // FMV.X.W and FMV.W.X
   } fpu_op_e;

   // Micro-ops executed by the datapath
   typedef enum logic [3:0] {
      uop_ready,                       // Idle, busy low
      uop_load_xy,                     // X <- A, Y <- (+/-)B
      uop_load_xy_mul,                 // X <- norm(A*B)
      uop_add_swap,                    // Larger magnitude into Y
      uop_add_shift,                   // Align X on Y exponent
      uop_add_add,                     // X <- X + Y, prepare normalization
      uop_add_norm,                    // X <- norm(X)
      uop_cmp,                         // Result <- FEQ/FLT/FLE
      uop_min_max                      // Result <- min or max
   } uop_e;

   // One ROM word
   typedef struct packed {
      logic exit_flag;                 // Last word of its program
      uop_e op;
   } uop_word_t;

   // A/B operand registers, frac carries the hidden one
   typedef struct packed {
      logic             sign;
      logic [exp_w-1:0] exp;
      logic [man_w:0]   frac;
   } fp_reg_t;

   // X/Y wide registers, value is frac * 2^(exp-127-47)
   typedef struct packed {
      logic                          sign;
      logic signed [exp_w:0]         exp;
      logic signed [wide_frac_w-1:0] frac;
   } wide_reg_t;

endpackage

`default_nettype wire

// ==== verilog/fpu_clz.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_clz #(
   parameter int width = 64               // Power of two, at least 2
) (
   input  logic [width-1:0]         in,
   output logic [$clog2(width)-1:0] count
);

   generate
      if (width == 2) begin : g_leaf
         assign count = ~in[1];
      end else begin : g_split
         logic [$clog2(width)-2:0] half_count;
         logic [width/2-1:0]       upper;
         logic [width/2-1:0]       lower;
         logic                     upper_empty;

         assign upper       = in[width-1:width/2];
         assign lower       = in[width/2-1:0];
         assign upper_empty = ~|upper;

         // Count in whichever half holds the first one
         fpu_clz #(.width(width/2)) u_half (
            .in    (upper_empty ? lower : upper),
            .count (half_count)
         );

         assign count = {upper_empty, half_count};   // MSB adds width/2
      end
   endgenerate

endmodule

`default_nettype wire

// ==== verilog/fpu_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_compare (
   input  fpu_pkg::wide_reg_t  x,
   input  fpu_pkg::wide_reg_t  y,
   output logic signed [8:0]   exp_diff,
   output logic                y_abs_lt_x,
   output logic                x_lt_y,
   output logic                x_le_y,
   output logic                x_eq_y
);
   import fpu_pkg::*;

   logic signed [wide_frac_w:0] frac_diff;
   logic exp_eq;
   logic frac_eq;
   logic x_abs_lt_y;
   logic x_abs_le_y;
   logic y_abs_le_x;

   // Both differences taken as Y - X
   assign exp_diff  = $signed(y.exp) - $signed(x.exp);
   assign frac_diff = $signed(y.frac) - $signed(x.frac);

   assign exp_eq  = (exp_diff == '0);
   assign frac_eq = (frac_diff == '0);

   // Magnitude relations, exponent first then fraction
   assign x_abs_lt_y = (!exp_diff[8] && !exp_eq) ||
                       (exp_eq && !frac_eq && !frac_diff[wide_frac_w]);
   assign x_abs_le_y = (!exp_diff[8] && !exp_eq) ||
                       (exp_eq && !frac_diff[wide_frac_w]);
   assign y_abs_lt_x = exp_diff[8] || (exp_eq && frac_diff[wide_frac_w]);
   assign y_abs_le_x = exp_diff[8] ||
                       (exp_eq && (frac_diff[wide_frac_w] || frac_eq));

   // Signed relations, negative zero orders below positive zero
   assign x_lt_y = (x.sign && !y.sign) ||
                   (x.sign && y.sign && y_abs_lt_x) ||
                   (!x.sign && !y.sign && x_abs_lt_y);
   assign x_le_y = (x.sign && !y.sign) ||
                   (x.sign && y.sign && y_abs_le_x) ||
                   (!x.sign && !y.sign && x_abs_le_y);
   assign x_eq_y = exp_eq && frac_eq && (x.sign == y.sign);

endmodule

`default_nettype wire

// ==== verilog/fpu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_decoder (
   input  logic [31:2]       instr,
   output fpu_pkg::fpu_op_e  op
);
   import fpu_pkg::*;

   logic [4:0] funct5;
   logic [2:0] rm;
   logic       is_op_fp;

   assign funct5   = instr[31:27];
   assign rm       = instr[14:12];
   assign is_op_fp = (instr[6:2] == 5'b10100);   // OP-FP major opcode, excludes fused ops

   always_comb begin
      op = op_none;                              // Dropped or unknown
      if (is_op_fp) begin
         case (funct5)
            5'b00000: op = op_fadd;
            5'b00001: op = op_fsub;
            5'b00010: op = op_fmul;
            5'b00100: begin
               // Sign injection variant in rm
               case (rm)
                  3'b000:  op = op_fsgnj;
                  3'b001:  op = op_fsgnjn;
                  3'b010:  op = op_fsgnjx;
                  default: op = op_none;
               endcase
            end
            5'b00101: begin
               case (rm)
                  3'b000:  op = op_fmin;
                  3'b001:  op = op_fmax;
                  default: op = op_none;
               endcase
            end
            5'b10100: begin
               case (rm)
                  3'b010:  op = op_feq;
                  3'b001:  op = op_flt;
                  3'b000:  op = op_fle;
                  default: op = op_none;
               endcase
            end
            5'b11100: op = rm[0] ? op_fclass : op_fmv;   // Same funct7, split by rm
            5'b11110: op = op_fmv;                       // FMV.W.X
            default:  op = op_none;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/fpu_microcode.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_microcode (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                wr,
   input  fpu_pkg::fpu_op_e    op,
   output fpu_pkg::uop_word_t  uop,
   output logic                busy
);
   import fpu_pkg::*;

   // Program start addresses in the ROM
   localparam logic [upc_w-1:0] prog_cmp     = 4'd1;
   localparam logic [upc_w-1:0] prog_add     = 4'd3;
   localparam logic [upc_w-1:0] prog_mul     = 4'd8;
   localparam logic [upc_w-1:0] prog_min_max = 4'd9;

   logic [upc_w-1:0] upc;
   logic [upc_w-1:0] upc_next;
   logic [upc_w-1:0] start_addr;
   logic             start;

   // Micro-op ROM
   function automatic uop_word_t rom(input logic [upc_w-1:0] addr);
      case (addr)
         4'd1:    rom = '{exit_flag: 1'b0, op: uop_load_xy};
         4'd2:    rom = '{exit_flag: 1'b1, op: uop_cmp};
         4'd3:    rom = '{exit_flag: 1'b0, op: uop_load_xy};
         4'd4:    rom = '{exit_flag: 1'b0, op: uop_add_swap};
         4'd5:    rom = '{exit_flag: 1'b0, op: uop_add_shift};
         4'd6:    rom = '{exit_flag: 1'b0, op: uop_add_add};
         4'd7:    rom = '{exit_flag: 1'b1, op: uop_add_norm};
         4'd8:    rom = '{exit_flag: 1'b1, op: uop_load_xy_mul};
         4'd9:    rom = '{exit_flag: 1'b0, op: uop_load_xy};
         4'd10:   rom = '{exit_flag: 1'b1, op: uop_min_max};
         default: rom = '{exit_flag: 1'b1, op: uop_ready};   // Address 0 and spare
      endcase
   endfunction

   always_comb begin
      case (op)
         op_fadd, op_fsub:        start_addr = prog_add;
         op_fmul:                 start_addr = prog_mul;
         op_feq, op_flt, op_fle:  start_addr = prog_cmp;
         op_fmin, op_fmax:        start_addr = prog_min_max;
         default:                 start_addr = '0;   // Single-cycle or none
      endcase
   end

   assign busy  = (uop.op != uop_ready);
   assign start = wr && !busy;          // Strobe during a program is dropped

   assign upc_next = start         ? start_addr :
                     uop.exit_flag ? '0         :
                                     upc + 1'b1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         upc <= '0;
         uop <= '{exit_flag: 1'b1, op: uop_ready};
      end else begin
         upc <= upc_next;
         uop <= rom(upc_next);           // Registered word drives the datapath
      end
   end

endmodule

`default_nettype wire

// ==== verilog/fpu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_datapath #(
   parameter int clz_width = 64
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                wr,
   input  fpu_pkg::fpu_op_e    op,
   input  logic [31:0]         rs1,
   input  logic [31:0]         rs2,
   input  fpu_pkg::uop_word_t  uop,
   output logic [31:0]         out
);
   import fpu_pkg::*;

   localparam int cnt_w = $clog2(clz_width);
   localparam int pad_w = clz_width - (wide_frac_w + 1);
   localparam int clz_off = clz_width - 1 - norm_bit;   // CLZ of a normalized sum

   fpu_op_e   op_q;
   fp_reg_t   a, b;
   wide_reg_t x, y;
   wide_reg_t x_mul;                    // Next X for load_xy_mul
   wide_reg_t x_norm;                   // Next X for add_norm
   logic [31:0] res;
   logic        start;

   logic signed [8:0]           exp_diff;
   logic                        y_abs_lt_x, x_lt_y, x_le_y, x_eq_y;
   logic signed [wide_frac_w:0] frac_sum;
   logic [clz_width-1:0]        clz_in;
   logic [cnt_w-1:0]            sum_clz;
   logic [cnt_w-1:0]            norm_lshamt;
   logic signed [8:0]           x_exp_norm;
   logic [wide_frac_w-1:0]      prod_frac;
   logic signed [9:0]           prod_exp;
   logic                        prod_z;
   logic                        rs1_exp_z, rs1_exp_max, rs1_frac_z;
   logic [9:0]                  fclass;

   // Unpack a word, subnormals become zero
   function automatic fp_reg_t load_ftz(input logic [31:0] w);
      load_ftz.sign = w[31];
      load_ftz.exp  = w[30:23];
      load_ftz.frac = (|w[30:23]) ? {1'b1, w[22:0]} : '0;
   endfunction

   // Top 32 bits of a wide register as an IEEE word
   function automatic logic [31:0] to_word(input wide_reg_t w);
      to_word = {w.sign, w.exp[exp_w-1:0], w.frac[norm_bit-1 -: man_w]};
   endfunction

   assign start = wr && (uop.op == uop_ready);   // Accepted only when idle
   assign out   = res;

   fpu_compare u_compare (
      .x          (x),
      .y          (y),
      .exp_diff   (exp_diff),
      .y_abs_lt_x (y_abs_lt_x),
      .x_lt_y     (x_lt_y),
      .x_le_y     (x_le_y),
      .x_eq_y     (x_eq_y)
   );

   // Adder and leading-zero count on the sum
   assign frac_sum = $signed(y.frac) + $signed(x.frac);
   assign clz_in   = {{pad_w{1'b0}}, frac_sum};

   fpu_clz #(.width(clz_width)) u_clz (
      .in    (clz_in),
      .count (sum_clz)
   );

   // Product, leading one lands on bit 47 or 46
   assign prod_frac = wide_frac_w'(a.frac) * wide_frac_w'(b.frac);
   assign prod_exp  = $signed({2'b0, a.exp}) + $signed({2'b0, b.exp}) - 10'(exp_bias)
                      + $signed({9'b0, prod_frac[norm_bit]});
   assign prod_z    = (prod_exp <= 0) || !(|prod_frac[norm_bit -: 2]);   // Zero or underflow

   always_comb begin
      x_mul.sign = a.sign ^ b.sign;
      if (prod_z) begin
         x_mul.exp  = '0;
         x_mul.frac = '0;
      end else begin
         x_mul.exp  = prod_exp[8:0];
         x_mul.frac = prod_frac[norm_bit] ? prod_frac : prod_frac << 1;
      end
   end

   always_comb begin
      if (x_exp_norm <= 0 || x.frac == '0) begin
         x_norm = '0;                    // Flush to +0
      end else begin
         x_norm.sign = x.sign;
         x_norm.exp  = x_exp_norm;
         // Carry out of bit 47 needs a right shift
         x_norm.frac = x.frac[norm_bit+1] ? x.frac >> 1 : x.frac << norm_lshamt;
      end
   end

   // FCLASS mask
   assign rs1_exp_z   = (rs1[30:23] == 8'h00);
   assign rs1_exp_max = (rs1[30:23] == 8'hff);
   assign rs1_frac_z  = (rs1[22:0] == '0);
   assign fclass = {
      rs1_exp_max &  rs1[22],                          // 9 quiet NaN
      rs1_exp_max & ~rs1[22] & ~rs1_frac_z,            // 8 signaling NaN
      ~rs1[31] &  rs1_exp_max & rs1_frac_z,            // 7 +inf
      ~rs1[31] & ~rs1_exp_z   & ~rs1_exp_max,          // 6 +normal
      ~rs1[31] &  rs1_exp_z   & ~rs1_frac_z,           // 5 +subnormal
      ~rs1[31] &  rs1_exp_z   &  rs1_frac_z,           // 4 +0
       rs1[31] &  rs1_exp_z   &  rs1_frac_z,           // 3 -0
       rs1[31] &  rs1_exp_z   & ~rs1_frac_z,           // 2 -subnormal
       rs1[31] & ~rs1_exp_z   & ~rs1_exp_max,          // 1 -normal
       rs1[31] &  rs1_exp_max &  rs1_frac_z            // 0 -inf
   };

   // Result register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         res <= '0;
      end else if (start) begin
         case (op)
            op_fsgnj:  res <= {rs2[31], rs1[30:0]};
            op_fsgnjn: res <= {~rs2[31], rs1[30:0]};
            op_fsgnjx: res <= {rs1[31] ^ rs2[31], rs1[30:0]};
            op_fclass: res <= {22'b0, fclass};
            op_fmv:    res <= rs1;
            default:   ;                 // Multi-cycle or none keeps result
         endcase
      end else begin
         case (uop.op)
            uop_load_xy_mul: res <= to_word(x_mul);
            uop_add_norm:    res <= to_word(x_norm);
            uop_cmp: res <= {31'b0, (op_q == op_flt && x_lt_y) ||
                                    (op_q == op_fle && x_le_y) ||
                                    (op_q == op_feq && x_eq_y)};
            uop_min_max: res <= (x_lt_y ^ (op_q == op_fmax)) ? to_word(x) : to_word(y);
            default: ;
         endcase
      end
   end

   // Operand and working registers
   always_ff @(posedge clk) begin
      if (start) begin
         op_q <= op;
         a    <= load_ftz(rs1);
         b    <= load_ftz(rs2);
      end else begin
         case (uop.op)
            uop_load_xy: begin
               x <= '{sign: a.sign, exp: {1'b0, a.exp}, frac: {2'b0, a.frac, 24'd0}};
               y <= '{sign: b.sign ^ (op_q == op_fsub), exp: {1'b0, b.exp},
                      frac: {2'b0, b.frac, 24'd0}};
            end
            uop_load_xy_mul: x <= x_mul;
            uop_add_swap: begin
               // Negate the smaller one so the add is always a sum
               if (y_abs_lt_x) begin
                  x.frac <= (x.sign ^ y.sign) ? -y.frac : y.frac;
                  x.exp  <= y.exp;
                  x.sign <= y.sign;
                  y      <= x;
               end else if (x.sign ^ y.sign) begin
                  x.frac <= -x.frac;
               end
            end
            uop_add_shift: begin
               x.frac <= $signed(x.frac) >>> exp_diff;   // Keeps the sign
               x.exp  <= y.exp;
            end
            uop_add_add: begin
               x.frac      <= frac_sum[wide_frac_w-1:0];
               x.sign      <= y.sign;
               norm_lshamt <= sum_clz - cnt_w'(clz_off);
               x_exp_norm  <= x.exp + 9'(clz_off) - 9'(sum_clz);
            end
            uop_add_norm: x <= x_norm;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/fpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        wr,
   input  logic [31:2] instr,
   input  logic [31:0] rs1,
   input  logic [31:0] rs2,
   output logic        busy,
   output logic [31:0] out
);
   import fpu_pkg::*;

   localparam int clz_width = 64;      // Holds the 51-bit sum

   fpu_op_e   op;
   uop_word_t uop;

   // Instruction word to operation
   fpu_decoder u_decoder (
      .instr (instr),
      .op    (op)
   );

   // Micro-program sequencer
   fpu_microcode u_microcode (
      .clk    (clk),
      .arst_n (arst_n),
      .wr     (wr),
      .op     (op),
      .uop    (uop),
      .busy   (busy)
   );

   // Registers and execution units
   fpu_datapath #(
      .clz_width (clz_width)
   ) u_datapath (
      .clk    (clk),
      .arst_n (arst_n),
      .wr     (wr),
      .op     (op),
      .rs1    (rs1),
      .rs2    (rs2),
      .uop    (uop),
      .out    (out)
   );

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int half_period  = 50,    // ns
   parameter int reset_cycles = 8
) (
   output logic clk,
   output logic arst_n
);

   // Free-running clock
   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // Reset held low for reset_cycles rising edges
   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1 arst_n = 1'b1;                 // Released just after the edge
   end

endmodule

`default_nettype wire

// ==== verification/fpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;

   localparam int half_period  = 50;   // 100 ns clock
   localparam int reset_cycles = 8;
   localparam int busy_limit   = 16;   // Longest program is 5
   localparam int random_count = 12;

   // One table row
   typedef struct packed {
      logic [31:0] instr;
      logic [31:0] rs1;
      logic [31:0] rs2;
      logic [31:0] exp_out;
      logic [7:0]  exp_busy;            // Cycles with busy high
      logic        poke;                // Second wr while busy
   } test_t;

   // OP-FP word with rs1=x1, rs2=x2, rd=x3
   function automatic logic [31:0] fp_instr(input logic [4:0] funct5, input logic [2:0] rm);
      return {funct5, 2'b00, 5'd2, 5'd1, rm, 5'd3, 7'b1010011};
   endfunction

   localparam logic [31:0] i_fadd    = fp_instr(5'b00000, 3'b001);   // rm = RTZ
   localparam logic [31:0] i_fsub    = fp_instr(5'b00001, 3'b001);
   localparam logic [31:0] i_fmul    = fp_instr(5'b00010, 3'b001);
   localparam logic [31:0] i_fdiv    = fp_instr(5'b00011, 3'b001);   // Dropped
   localparam logic [31:0] i_fsgnj   = fp_instr(5'b00100, 3'b000);
   localparam logic [31:0] i_fsgnjn  = fp_instr(5'b00100, 3'b001);
   localparam logic [31:0] i_fsgnjx  = fp_instr(5'b00100, 3'b010);
   localparam logic [31:0] i_sgn_bad = fp_instr(5'b00100, 3'b011);   // Reserved rm
   localparam logic [31:0] i_fmin    = fp_instr(5'b00101, 3'b000);
   localparam logic [31:0] i_fmax    = fp_instr(5'b00101, 3'b001);
   localparam logic [31:0] i_feq     = fp_instr(5'b10100, 3'b010);
   localparam logic [31:0] i_flt     = fp_instr(5'b10100, 3'b001);
   localparam logic [31:0] i_fle     = fp_instr(5'b10100, 3'b000);
   localparam logic [31:0] i_fclass  = fp_instr(5'b11100, 3'b001);
   localparam logic [31:0] i_fmv_x_w = fp_instr(5'b11100, 3'b000);
   localparam logic [31:0] i_fmv_w_x = fp_instr(5'b11110, 3'b000);
   localparam logic [31:0] i_fmadd   = {5'd0, 2'b00, 5'd2, 5'd1, 3'b000, 5'd1, 7'b1000011};

   logic        clk;
   logic        arst_n;
   logic        wr;
   logic [31:2] instr;
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic        busy;
   logic [31:0] out;

   test_t tests[$];
   logic  table_ready = 1'b0;

   tb_clock #(
      .half_period  (half_period),
      .reset_cycles (reset_cycles)
   ) u_clock (
      .clk    (clk),
      .arst_n (arst_n)
   );

   fpu_top dut0 (
      .clk    (clk),
      .arst_n (arst_n),
      .wr     (wr),
      .instr  (instr),
      .rs1    (rs1),
      .rs2    (rs2),
      .busy   (busy),
      .out    (out)
   );

   // Prints the reason and ends the run
   task automatic report_failure(input string reason);
      $display("%s", reason);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
      report_failure($sformatf("Mismatch at %0t: %s = 0x%08h, expected 0x%08h",
                               $time, name, got, expected));
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic add_test(input logic [31:0] t_instr, input logic [31:0] t_rs1,
                           input logic [31:0] t_rs2, input logic [31:0] t_out,
                           input int t_busy, input bit t_poke);
      test_t t;
      t = '{instr: t_instr, rs1: t_rs1, rs2: t_rs2, exp_out: t_out,
            exp_busy: 8'(t_busy), poke: t_poke};
      tests.push_back(t);
   endtask

   task automatic build_table();
      logic [31:0] state;
      logic [31:0] a_word;
      logic [31:0] b_word;
      int          k;
      // Add and subtract with truncation and flushing
      add_test(i_fadd, 32'h3f800000, 32'h40000000, 32'h40400000, 5, 0);   // 1 + 2
      add_test(i_fadd, 32'h3f800000, 32'h3f800000, 32'h40000000, 5, 0);   // Carry out
      add_test(i_fsub, 32'h3fc00000, 32'h3f000000, 32'h3f800000, 5, 0);   // 1.5 - 0.5
      add_test(i_fsub, 32'h3f800000, 32'h3f800000, 32'h00000000, 5, 0);   // x - x = +0
      add_test(i_fsub, 32'h3fc00000, 32'h3fa00000, 32'h3e800000, 5, 0);   // Left normalize
      add_test(i_fadd, 32'h3f800000, 32'hc0400000, 32'hc0000000, 5, 0);   // 1 + -3
      add_test(i_fadd, 32'h3f800000, 32'h33ffffff, 32'h3f800000, 5, 0);   // Tail truncated
      add_test(i_fadd, 32'h00800000, 32'h00400000, 32'h00800000, 5, 0);   // Denormal is zero
      // Multiply
      add_test(i_fmul, 32'h3fc00000, 32'h40000000, 32'h40400000, 1, 0);   // 1.5 * 2
      add_test(i_fmul, 32'hc0000000, 32'h3e800000, 32'hbf000000, 1, 0);   // -2 * 0.25
      add_test(i_fmul, 32'h3fc00000, 32'h3fc00000, 32'h40100000, 1, 0);   // Product >= 2
      add_test(i_fmul, 32'h0d800000, 32'h0d800000, 32'h00000000, 1, 0);   // Underflow
      // Compare with -0 below +0
      add_test(i_feq, 32'h3f800000, 32'h3f800000, 32'd1, 2, 0);
      add_test(i_feq, 32'h00000000, 32'h80000000, 32'd0, 2, 0);
      add_test(i_feq, 32'h3f800000, 32'h3fc00000, 32'd0, 2, 0);
      add_test(i_flt, 32'h3f800000, 32'h40000000, 32'd1, 2, 0);
      add_test(i_flt, 32'h40000000, 32'h3f800000, 32'd0, 2, 0);
      add_test(i_flt, 32'hbf800000, 32'h3f800000, 32'd1, 2, 0);           // Mixed signs
      add_test(i_flt, 32'h80000000, 32'h00000000, 32'd1, 2, 0);
      add_test(i_flt, 32'hc0000000, 32'hbf800000, 32'd1, 2, 0);           // Both negative
      add_test(i_fle, 32'h3f800000, 32'h3f800000, 32'd1, 2, 0);
      add_test(i_fle, 32'hbf800000, 32'hc0000000, 32'd0, 2, 0);
      add_test(i_fle, 32'h00000000, 32'h80000000, 32'd0, 2, 0);
      // Min and max
      add_test(i_fmin, 32'h3f800000, 32'h40000000, 32'h3f800000, 2, 0);
      add_test(i_fmax, 32'hbf800000, 32'h3f000000, 32'h3f000000, 2, 0);
      add_test(i_fmin, 32'h80000000, 32'h00000000, 32'h80000000, 2, 0);
      add_test(i_fmax, 32'h40400000, 32'h3fc00000, 32'h40400000, 2, 0);
      add_test(i_fmin, 32'hc0000000, 32'hbf800000, 32'hc0000000, 2, 0);
      // Sign injection
      add_test(i_fsgnj, 32'h3f800000, 32'hc0000000, 32'hbf800000, 0, 0);
      add_test(i_fsgnjn, 32'hbf800000, 32'hc0000000, 32'h3f800000, 0, 0);
      add_test(i_fsgnjx, 32'hbf800000, 32'hc0000000, 32'h3f800000, 0, 0);
      add_test(i_fsgnjx, 32'h3fc00000, 32'h80000000, 32'hbfc00000, 0, 0);
      // One mask bit per class
      add_test(i_fclass, 32'hff800000, '0, 32'h001, 0, 0);                // -inf
      add_test(i_fclass, 32'hbf800000, '0, 32'h002, 0, 0);
      add_test(i_fclass, 32'h80400000, '0, 32'h004, 0, 0);                // -subnormal
      add_test(i_fclass, 32'h80000000, '0, 32'h008, 0, 0);
      add_test(i_fclass, 32'h00000000, '0, 32'h010, 0, 0);
      add_test(i_fclass, 32'h00000001, '0, 32'h020, 0, 0);
      add_test(i_fclass, 32'h3f800000, '0, 32'h040, 0, 0);
      add_test(i_fclass, 32'h7f800000, '0, 32'h080, 0, 0);                // +inf
      add_test(i_fclass, 32'h7f800001, '0, 32'h100, 0, 0);                // sNaN
      add_test(i_fclass, 32'h7fc00000, '0, 32'h200, 0, 0);                // qNaN
      add_test(i_fmv_x_w, 32'h12345678, 32'h0, 32'h12345678, 0, 0);
      add_test(i_fmv_w_x, 32'hcafef00d, 32'h0, 32'hcafef00d, 0, 0);
      // Dropped instructions keep the last result
      add_test(i_fdiv, 32'h40000000, 32'h3f800000, 32'hcafef00d, 0, 0);
      add_test(i_fmadd, 32'h40000000, 32'h3f800000, 32'hcafef00d, 0, 0);
      add_test(i_sgn_bad, 32'h40000000, 32'h3f800000, 32'hcafef00d, 0, 0);
      // Second strobe lands inside the busy window
      add_test(i_fadd, 32'h3f800000, 32'h40000000, 32'h40400000, 5, 1);
      add_test(i_fmul, 32'h3fc00000, 32'h40000000, 32'h40400000, 1, 1);
      // Random FSGNJX flips the rs1 sign when rs2 is negative
      state = 32'hb487;
      for (k = 0; k < random_count; k++) begin
         state  = lcg_next(state);
         a_word = state;
         state  = lcg_next(state);
         b_word = state;
         add_test(i_fsgnjx, a_word, b_word, a_word ^ {b_word[31], 31'd0}, 0, 0);
      end
   endtask

   task automatic apply_test(input test_t t, input int idx);
      int count;
      @(posedge clk);
      #1;
      instr = t.instr[31:2];
      rs1   = t.rs1;
      rs2   = t.rs2;
      wr    = 1'b1;
      @(posedge clk);
      #1;
      if (t.poke) begin
         instr = i_fmv_x_w[31:2];        // Would overwrite the result if taken
         rs1   = 32'hdeadbeef;
         rs2   = 32'h0badf00d;
      end else begin
         wr = 1'b0;
      end
      count = 0;
      while (busy === 1'b1 && count < busy_limit) begin
         count++;
         @(posedge clk);
         #1;
         wr = 1'b0;
      end
      assert (busy === 1'b0)
         else report_failure($sformatf("Test %0d: busy still high after %0d cycles",
                                       idx, count));
      assert (count == int'(t.exp_busy))
         else report_mismatch($sformatf("busy cycles (test %0d)", idx), count,
                              32'(t.exp_busy));
      assert (out === t.exp_out)
         else report_mismatch($sformatf("out (test %0d)", idx), out, t.exp_out);
   endtask

   initial begin
      wr    = 1'b0;
      instr = '0;
      rs1   = '0;
      rs2   = '0;
      build_table();
      table_ready = 1'b1;
      wait (arst_n === 1'b1);
      @(posedge clk);
      #1;
      assert (busy === 1'b0) else report_mismatch("busy after reset", 32'(busy), 32'h0);
      assert (out === 32'h0) else report_mismatch("out after reset", out, 32'h0);
      foreach (tests[i]) begin
         apply_test(tests[i], i);
      end
      $display("Simulation PASSED");
      $finish;
   end

   // Watchdog allows 20 cycles per row plus reset
   initial begin : watchdog
      int limit;
      wait (table_ready);
      limit = tests.size() * 20 + reset_cycles;
      repeat (limit) @(posedge clk);
      report_failure($sformatf("Timeout: tests did not finish within %0d cycles", limit));
   end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/fpu_pkg.sv
verilog/fpu_clz.sv
verilog/fpu_compare.sv
verilog/fpu_decoder.sv
verilog/fpu_microcode.sv
verilog/fpu_datapath.sv
verilog/fpu_top.sv
verification/tb_clock.sv
verification/fpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module fpu_tb \
   --Mdir obj_dir -o fpu_sim
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/fpu_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status"
   exit 1
fi

# Only the pass line marks success
if printf '%s\n' "$sim_out" | grep -qx "Simulation PASSED"; then
   exit 0
else
   echo "Pass message not found"
   exit 1
fi
